//--- sources.f
+incdir+tb
verilog/issue_pkg.sv
verilog/issue_pair_buffer.sv
verilog/issue_scheduler.sv
verilog/issue_regfile.sv
verilog/operand_bypass.sv
verilog/exec_pipe.sv
verilog/issue_top.sv
tb/issue_tb.sv

//--- tb/issue_tb_util.svh
`ifndef ISSUE_TB_UTIL_SVH
`define ISSUE_TB_UTIL_SVH

// ------------------------------------------------------------
// Random bits
// ------------------------------------------------------------
// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
        lfsr_q = lfsr_step(lfsr_q);
        value  = {value[30:0], lfsr_q[0]};
    end
    return value;
endfunction

// ------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------
task automatic compare_commit(input string name, input issue_pkg::commit_t exp,
                              input issue_pkg::commit_t act);
    if (exp !== act)
    begin
        mismatch_errors++;
        $display("mismatch %s: expected rd %0d result %h, actual rd %0d result %h",
                 name, exp.rd, exp.result, act.rd, act.result);
    end
endtask

task automatic compare_count(input string name, input int exp, input int act);
    if (exp != act)
    begin
        mismatch_errors++;
        $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
        mismatch_errors++;
        $display("mismatch %s: expected %b, actual %b", name, exp, act);
    end
endtask

`endif

//--- tb/issue_tb.sv
`timescale 1ns/10ps

module issue_tb;

localparam int CLK_HALF   = 10;
localparam int NUM_PAIRS  = 300;
localparam int WAIT_LIMIT = 200;

logic                   clk_i;
logic                   rst_i;
logic                   in_valid_i;
issue_pkg::fetch_pair_t in_pair_i;
logic                   in_ready_o;
logic                   commit0_valid_o;
issue_pkg::commit_t     commit0_o;
logic                   commit1_valid_o;
issue_pkg::commit_t     commit1_o;

logic [31:0] lfsr_q;
logic [31:0] seed_value;
logic        timed_out;
string       test_name;
int          mismatch_errors;
int          other_errors;
int          sent_count;
int          commit_count;
int          dual_count;

// Reference model: architectural registers and commits still to come
logic [issue_pkg::XLEN-1:0] model_regs [issue_pkg::NUM_REGS];
issue_pkg::commit_t         expected_q [$];

`include "issue_tb_util.svh"

issue_top issue_top_inst
(
     .clk_i           (clk_i)
    ,.rst_i           (rst_i)
    ,.in_valid_i      (in_valid_i)
    ,.in_pair_i       (in_pair_i)
    ,.in_ready_o      (in_ready_o)
    ,.commit0_valid_o (commit0_valid_o)
    ,.commit0_o       (commit0_o)
    ,.commit1_valid_o (commit1_valid_o)
    ,.commit1_o       (commit1_o)
);

initial
begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
end

// ------------------------------------------------------------
// Model and stimulus helpers
// ------------------------------------------------------------
function automatic issue_pkg::instr_t make_instr(input issue_pkg::opcode_e op,
                                                 input int rd, input int ra, input int rb);
    issue_pkg::instr_t instr;
    instr.opcode = op;
    instr.rd     = 5'(rd);
    instr.ra     = 5'(ra);
    instr.rb     = 5'(rb);
    return instr;
endfunction

// Small register range keeps hazards frequent
function automatic issue_pkg::instr_t random_instr();
    issue_pkg::opcode_e op;
    op = issue_pkg::opcode_e'(3'(take_bits(3) % 6));
    return make_instr(op, take_bits(3), take_bits(3), take_bits(3));
endfunction

function automatic void run_model(input issue_pkg::instr_t instr);
    logic [issue_pkg::XLEN-1:0] a;
    logic [issue_pkg::XLEN-1:0] b;
    logic [issue_pkg::XLEN-1:0] r;
    issue_pkg::commit_t         c;
    a = model_regs[instr.ra];
    b = model_regs[instr.rb];
    case (instr.opcode)
        issue_pkg::OP_ADD: r = a + b;
        issue_pkg::OP_SUB: r = a - b;
        issue_pkg::OP_AND: r = a & b;
        issue_pkg::OP_OR:  r = a | b;
        issue_pkg::OP_XOR: r = a ^ b;
        default:           r = a * b;
    endcase
    c.rd     = instr.rd;
    c.result = r;
    expected_q.push_back(c);
    // Register 0 keeps reading as zero
    if (instr.rd != 0)
        model_regs[instr.rd] = r;
    sent_count++;
endfunction

function automatic void seed_model(input int idx, input logic [31:0] value);
    issue_pkg::commit_t c;
    c.rd     = 5'(idx);
    c.result = value;
    expected_q.push_back(c);
    model_regs[idx] = value;
    sent_count++;
endfunction

function automatic logic [31:0] seed_choice(input int idx);
    case (idx)
        1:       return 32'h8000_0001;
        2:       return 32'h0000_00ff;
        3:       return 32'h1234_5678;
        4:       return 32'hffff_fff0;
        default: return 32'h0f0f_a5a5;
    endcase
endfunction

// Ready does not depend on the inputs, so it is stable at the falling edge
task automatic send_pair(input issue_pkg::fetch_pair_t pair);
    int waited;
    waited = 0;
    if (timed_out)
        return;
    @(negedge clk_i);
    in_valid_i = 1'b1;
    in_pair_i  = pair;
    while (!in_ready_o && !timed_out)
    begin
        @(negedge clk_i);
        waited++;
        if (waited > WAIT_LIMIT)
        begin
            other_errors++;
            timed_out = 1'b1;
            $display("%s: in_ready_o stayed low for %0d cycles", test_name, waited);
        end
    end
endtask

task automatic idle_cycle();
    @(negedge clk_i);
    in_valid_i = 1'b0;
    in_pair_i  = '0;
endtask

task automatic wait_drained();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && !timed_out)
    begin
        @(negedge clk_i);
        waited++;
        if (waited > WAIT_LIMIT)
        begin
            other_errors++;
            timed_out = 1'b1;
            $display("%s: %0d instructions never committed", test_name, expected_q.size());
        end
    end
endtask

task automatic check_commit(input string port, input issue_pkg::commit_t act);
    issue_pkg::commit_t exp;
    commit_count++;
    if (expected_q.size() == 0)
    begin
        other_errors++;
        $display("%s %s: commit of rd %0d with no instruction outstanding",
                 test_name, port, act.rd);
    end
    else
    begin
        exp = expected_q.pop_front();
        compare_commit({test_name, " ", port}, exp, act);
    end
endtask

task automatic finish_run();
    $display("error counts: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0)
        $display("No errors");
    else
        $display("Errors found");
    $finish;
endtask

// ------------------------------------------------------------
// Commit checking
// ------------------------------------------------------------
// Pipe 0 holds the older instruction, so it is popped first
always @(negedge clk_i)
begin
    if (!rst_i)
    begin
        if (commit1_valid_o && !commit0_valid_o)
        begin
            other_errors++;
            $display("%s: commit 1 valid without commit 0", test_name);
        end
        if (commit0_valid_o)
            check_commit("commit0", commit0_o);
        if (commit1_valid_o)
            check_commit("commit1", commit1_o);
        if (commit0_valid_o && commit1_valid_o)
            dual_count++;
    end
end

// ------------------------------------------------------------
// Main sequence
// ------------------------------------------------------------
initial
begin
    issue_pkg::fetch_pair_t pair;
    int                     dual_before;

    lfsr_q          = 32'h8af3638a;
    timed_out       = 1'b0;
    mismatch_errors = 0;
    other_errors    = 0;
    sent_count      = 0;
    commit_count    = 0;
    dual_count      = 0;
    seed_value      = '0;
    test_name       = "reset";
    for (int i = 0; i < issue_pkg::NUM_REGS; i++)
        model_regs[i] = '0;

    rst_i      = 1'b1;
    in_valid_i = 1'b0;
    in_pair_i  = '0;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;

    compare_bit("reset commit0 valid", 1'b0, commit0_valid_o);
    compare_bit("reset commit1 valid", 1'b0, commit1_valid_o);
    compare_bit("reset in_ready", 1'b1, in_ready_o);

    // The register file starts at zero, so each seed value enters as slot A's ra operand
    test_name = "seed";
    for (int k = 1; k <= 5; k++)
    begin
        pair        = '0;
        pair.valid0 = 1'b1;
        pair.instr0 = make_instr(issue_pkg::OP_ADD, k, k, 0);
        seed_value  = seed_choice(k);
        force issue_top_inst.u_bypass_a.ra_file_i = seed_value;
        send_pair(pair);
        seed_model(k, seed_choice(k));
        idle_cycle();
        wait_drained();
        release issue_top_inst.u_bypass_a.ra_file_i;
    end

    // Independent ALU pair on an empty pipeline
    test_name   = "dual";
    dual_before = dual_count;
    pair        = '0;
    pair.valid0 = 1'b1;
    pair.instr0 = make_instr(issue_pkg::OP_ADD, 6, 1, 2);
    pair.valid1 = 1'b1;
    pair.instr1 = make_instr(issue_pkg::OP_XOR, 7, 3, 4);
    send_pair(pair);
    run_model(pair.instr0);
    run_model(pair.instr1);
    idle_cycle();
    wait_drained();
    compare_count("dual commit cycles", dual_before + 1, dual_count);

    test_name = "random";
    for (int n = 0; n < NUM_PAIRS; n++)
    begin
        if (take_bits(2) == 0)
            idle_cycle();
        pair        = '0;
        pair.valid0 = (take_bits(3) != 0);
        pair.instr0 = random_instr();
        pair.valid1 = (take_bits(3) != 0);
        pair.instr1 = random_instr();
        send_pair(pair);
        if (pair.valid0)
            run_model(pair.instr0);
        if (pair.valid1)
            run_model(pair.instr1);
    end
    idle_cycle();
    wait_drained();

    // A few quiet cycles expose duplicated commits
    repeat (8) @(negedge clk_i);
    compare_count("commit total", sent_count, commit_count);
    finish_run();
end

endmodule

//--- verilog/exec_pipe.sv
`timescale 1ns/10ps

module exec_pipe
#(
    parameter int SUPPORT_MUL = 1
)
(
     input  logic               clk_i
    ,input  logic               rst_i
    ,input  logic               issue_valid_i
    ,input  issue_pkg::issue_t  issue_i
    ,output issue_pkg::stage_t  e1_o
    ,output issue_pkg::stage_t  e2_o
    ,output issue_pkg::stage_t  wb_o
    ,output logic               commit_valid_o
    ,output issue_pkg::commit_t commit_o
);

logic                       e1_valid_q;
issue_pkg::issue_t          e1_q;
logic [issue_pkg::XLEN-1:0] alu_r;
logic [issue_pkg::XLEN-1:0] mul_lo_w;
issue_pkg::stage_t          e2_q;
issue_pkg::stage_t          wb_q;

// ------------------------------------------------------------
// E1
// ------------------------------------------------------------
always_ff @(posedge clk_i or posedge rst_i)
begin
    if (rst_i)
        e1_valid_q <= 1'b0;
    else
        e1_valid_q <= issue_valid_i;
end

always_ff @(posedge clk_i)
begin
    if (issue_valid_i)
        e1_q <= issue_i;
end

always_comb
begin
    case (e1_q.instr.opcode)
        issue_pkg::OP_ADD: alu_r = e1_q.ra_val + e1_q.rb_val;
        issue_pkg::OP_SUB: alu_r = e1_q.ra_val - e1_q.rb_val;
        issue_pkg::OP_AND: alu_r = e1_q.ra_val & e1_q.rb_val;
        issue_pkg::OP_OR:  alu_r = e1_q.ra_val | e1_q.rb_val;
        issue_pkg::OP_XOR: alu_r = e1_q.ra_val ^ e1_q.rb_val;
        default:           alu_r = '0;
    endcase
end

// Low half of the product, registered into E2
if (SUPPORT_MUL != 0)
begin : g_mul
    assign mul_lo_w = e1_q.ra_val * e1_q.rb_val;
end
else
begin : g_no_mul
    assign mul_lo_w = '0;
end

always_comb
begin
    e1_o.valid  = e1_valid_q;
    e1_o.wr     = (e1_q.instr.rd != '0);
    e1_o.is_mul = (e1_q.instr.opcode == issue_pkg::OP_MUL);
    e1_o.rd     = e1_q.instr.rd;
    e1_o.result = alu_r;
end

// ------------------------------------------------------------
// E2 and WB
// ------------------------------------------------------------
always_ff @(posedge clk_i or posedge rst_i)
begin
    if (rst_i)
    begin
        e2_q <= '0;
        wb_q <= '0;
    end
    else
    begin
        e2_q <= e1_o;
        if (e1_o.is_mul)
            e2_q.result <= mul_lo_w;
        wb_q <= e2_q;
    end
end

assign e2_o = e2_q;
assign wb_o = wb_q;

assign commit_valid_o  = wb_q.valid;
assign commit_o.rd     = wb_q.rd;
assign commit_o.result = wb_q.result;

// A pipe without a multiplier must never be handed a mul
a_no_mul_without_unit: assert property (@(posedge clk_i) disable iff (rst_i)
    (SUPPORT_MUL == 0) |-> !(e1_o.valid && e1_o.is_mul));

endmodule

//--- verilog/issue_pair_buffer.sv
`timescale 1ns/10ps

module issue_pair_buffer
(
     input  logic                   clk_i
    ,input  logic                   rst_i
    ,input  logic                   in_valid_i
    ,input  issue_pkg::fetch_pair_t in_pair_i
    ,output logic                   in_ready_o
    ,input  logic                   issue_a_i
    ,input  logic                   issue_b_i
    ,output issue_pkg::fetch_pair_t head_o
);

// Slot 1 is only ever valid when slot 0 is valid too
logic              valid0_q;
logic              valid1_q;
issue_pkg::instr_t instr0_q;
issue_pkg::instr_t instr1_q;

logic keep0_w;
logic load_w;

// ------------------------------------------------------------
// Occupancy after this cycle's issue
// ------------------------------------------------------------
// An issue of slot 0 alone leaves slot 1 behind, which then moves forward
assign keep0_w    = issue_a_i ? (valid1_q && !issue_b_i) : valid0_q;
assign in_ready_o = !keep0_w;
assign load_w     = in_valid_i && in_ready_o;

always_ff @(posedge clk_i or posedge rst_i)
begin
    if (rst_i)
    begin
        valid0_q <= 1'b0;
        valid1_q <= 1'b0;
    end
    else if (load_w)
    begin
        // A lone slot 1 instruction is packed into slot 0
        valid0_q <= in_pair_i.valid0 || in_pair_i.valid1;
        valid1_q <= in_pair_i.valid0 && in_pair_i.valid1;
    end
    else
    begin
        valid0_q <= keep0_w;
        valid1_q <= valid1_q && !issue_a_i;
    end
end

always_ff @(posedge clk_i)
begin
    if (load_w)
    begin
        instr0_q <= in_pair_i.valid0 ? in_pair_i.instr0 : in_pair_i.instr1;
        instr1_q <= in_pair_i.instr1;
    end
    else if (issue_a_i)
    begin
        instr0_q <= instr1_q;
    end
end

always_comb
begin
    head_o.valid0 = valid0_q;
    head_o.instr0 = instr0_q;
    head_o.valid1 = valid1_q;
    head_o.instr1 = instr1_q;
end

// ------------------------------------------------------------
// Checks
// ------------------------------------------------------------
// An empty buffer issues nothing and never holds off the source
a_ready_when_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    !valid0_q |-> (in_ready_o && !issue_a_i));

// The scheduler only sends slot B out together with a held slot A
a_b_with_a: assert property (@(posedge clk_i) disable iff (rst_i)
    issue_b_i |-> (issue_a_i && valid1_q));

endmodule

//--- verilog/issue_pkg.sv
package issue_pkg;

    // ------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;

    // Stage positions in the per-pipe status arrays
    localparam int STAGE_E1   = 0;
    localparam int STAGE_E2   = 1;
    localparam int STAGE_WB   = 2;
    localparam int NUM_STAGES = 3;

    // ------------------------------------------------------------
    // Instruction and status types
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_MUL = 3'd5
    } opcode_e;

    typedef struct packed {
        opcode_e              opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] ra;
        logic [REG_IDX_W-1:0] rb;
    } instr_t;

    // Slot 0 holds the older instruction
    typedef struct packed {
        logic   valid1;
        instr_t instr1;
        logic   valid0;
        instr_t instr0;
    } fetch_pair_t;

    typedef struct packed {
        instr_t          instr;
        logic [XLEN-1:0] ra_val;
        logic [XLEN-1:0] rb_val;
    } issue_t;

    // Status of one pipe stage for hazard checks and forwarding
    typedef struct packed {
        logic                 valid;
        logic                 wr;
        logic                 is_mul;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      result;
    } stage_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      result;
    } commit_t;

endpackage

//--- verilog/issue_regfile.sv
`timescale 1ns/10ps

module issue_regfile
(
     input  logic                            clk_i
    ,input  logic                            rst_i
    ,input  logic                            wr0_en_i
    ,input  logic [issue_pkg::REG_IDX_W-1:0] wr0_idx_i
    ,input  logic [issue_pkg::XLEN-1:0]      wr0_data_i
    ,input  logic                            wr1_en_i
    ,input  logic [issue_pkg::REG_IDX_W-1:0] wr1_idx_i
    ,input  logic [issue_pkg::XLEN-1:0]      wr1_data_i
    ,input  logic [issue_pkg::REG_IDX_W-1:0] ra0_idx_i
    ,input  logic [issue_pkg::REG_IDX_W-1:0] rb0_idx_i
    ,input  logic [issue_pkg::REG_IDX_W-1:0] ra1_idx_i
    ,input  logic [issue_pkg::REG_IDX_W-1:0] rb1_idx_i
    ,output logic [issue_pkg::XLEN-1:0]      ra0_data_o
    ,output logic [issue_pkg::XLEN-1:0]      rb0_data_o
    ,output logic [issue_pkg::XLEN-1:0]      ra1_data_o
    ,output logic [issue_pkg::XLEN-1:0]      rb1_data_o
);

logic [issue_pkg::XLEN-1:0] regs_q [issue_pkg::NUM_REGS];

// Register 0 is never written and stays zero
always_ff @(posedge clk_i or posedge rst_i)
begin
    if (rst_i)
    begin
        for (int i = 0; i < issue_pkg::NUM_REGS; i++)
            regs_q[i] <= '0;
    end
    else
    begin
        if (wr0_en_i && (wr0_idx_i != '0))
            regs_q[wr0_idx_i] <= wr0_data_i;
        // Port 1 holds the younger instruction and lands last
        if (wr1_en_i && (wr1_idx_i != '0))
            regs_q[wr1_idx_i] <= wr1_data_i;
    end
end

assign ra0_data_o = regs_q[ra0_idx_i];
assign rb0_data_o = regs_q[rb0_idx_i];
assign ra1_data_o = regs_q[ra1_idx_i];
assign rb1_data_o = regs_q[rb1_idx_i];

endmodule

//--- verilog/issue_scheduler.sv
`timescale 1ns/10ps

module issue_scheduler
(
     input  issue_pkg::fetch_pair_t head_i
    ,input  issue_pkg::stage_t      pipe0_e1_i
    ,input  issue_pkg::stage_t      pipe1_e1_i
    ,output logic                   issue_a_o
    ,output logic                   issue_b_o
);

logic [issue_pkg::NUM_REGS-1:0] scoreboard_r;
logic                           issue_a_r;
logic                           issue_b_r;
issue_pkg::instr_t              a_w;
issue_pkg::instr_t              b_w;

assign a_w = head_i.instr0;
assign b_w = head_i.instr1;

always_comb
begin
    scoreboard_r = '0;
    issue_a_r    = 1'b0;
    issue_b_r    = 1'b0;

    // A mul in E1 has no product yet
    if (pipe0_e1_i.valid && pipe0_e1_i.is_mul && pipe0_e1_i.wr)
        scoreboard_r[pipe0_e1_i.rd] = 1'b1;
    if (pipe1_e1_i.valid && pipe1_e1_i.is_mul && pipe1_e1_i.wr)
        scoreboard_r[pipe1_e1_i.rd] = 1'b1;

    // ------------------------------------------------------------
    // Slot A
    // ------------------------------------------------------------
    if (head_i.valid0 &&
        !(scoreboard_r[a_w.ra] || scoreboard_r[a_w.rb] || scoreboard_r[a_w.rd]))
    begin
        issue_a_r = 1'b1;

        // Slot B must not read or overwrite what A produces this cycle
        if (a_w.rd != '0)
            scoreboard_r[a_w.rd] = 1'b1;
    end

    // ------------------------------------------------------------
    // Slot B
    // ------------------------------------------------------------
    // Pipe 1 has no multiplier
    if (issue_a_r && head_i.valid1 && (b_w.opcode != issue_pkg::OP_MUL) &&
        !(scoreboard_r[b_w.ra] || scoreboard_r[b_w.rb] || scoreboard_r[b_w.rd]))
    begin
        issue_b_r = 1'b1;
    end
end

assign issue_a_o = issue_a_r;
assign issue_b_o = issue_b_r;

endmodule

//--- verilog/issue_top.sv
`timescale 1ns/10ps

module issue_top
(
     input  logic                   clk_i
    ,input  logic                   rst_i
    ,input  logic                   in_valid_i
    ,input  issue_pkg::fetch_pair_t in_pair_i
    ,output logic                   in_ready_o
    ,output logic                   commit0_valid_o
    ,output issue_pkg::commit_t     commit0_o
    ,output logic                   commit1_valid_o
    ,output issue_pkg::commit_t     commit1_o
);

issue_pkg::fetch_pair_t     head_w;
logic                       issue_a_w;
logic                       issue_b_w;
logic [issue_pkg::XLEN-1:0] ra0_w;
logic [issue_pkg::XLEN-1:0] rb0_w;
logic [issue_pkg::XLEN-1:0] ra1_w;
logic [issue_pkg::XLEN-1:0] rb1_w;
issue_pkg::issue_t          issue_a_data_w;
issue_pkg::issue_t          issue_b_data_w;

// Per-pipe status indexed by stage
issue_pkg::stage_t          pipe0_stage_w [issue_pkg::NUM_STAGES];
issue_pkg::stage_t          pipe1_stage_w [issue_pkg::NUM_STAGES];

// ------------------------------------------------------------
// Pair buffer and issue decision
// ------------------------------------------------------------
issue_pair_buffer u_pair_buffer
(
     .clk_i      (clk_i)
    ,.rst_i      (rst_i)
    ,.in_valid_i (in_valid_i)
    ,.in_pair_i  (in_pair_i)
    ,.in_ready_o (in_ready_o)
    ,.issue_a_i  (issue_a_w)
    ,.issue_b_i  (issue_b_w)
    ,.head_o     (head_w)
);

issue_scheduler u_scheduler
(
     .head_i     (head_w)
    ,.pipe0_e1_i (pipe0_stage_w[issue_pkg::STAGE_E1])
    ,.pipe1_e1_i (pipe1_stage_w[issue_pkg::STAGE_E1])
    ,.issue_a_o  (issue_a_w)
    ,.issue_b_o  (issue_b_w)
);

// ------------------------------------------------------------
// Operand read
// ------------------------------------------------------------
issue_regfile u_regfile
(
     .clk_i      (clk_i)
    ,.rst_i      (rst_i)
    ,.wr0_en_i   (pipe0_stage_w[issue_pkg::STAGE_WB].valid
                  && pipe0_stage_w[issue_pkg::STAGE_WB].wr)
    ,.wr0_idx_i  (pipe0_stage_w[issue_pkg::STAGE_WB].rd)
    ,.wr0_data_i (pipe0_stage_w[issue_pkg::STAGE_WB].result)
    ,.wr1_en_i   (pipe1_stage_w[issue_pkg::STAGE_WB].valid
                  && pipe1_stage_w[issue_pkg::STAGE_WB].wr)
    ,.wr1_idx_i  (pipe1_stage_w[issue_pkg::STAGE_WB].rd)
    ,.wr1_data_i (pipe1_stage_w[issue_pkg::STAGE_WB].result)
    ,.ra0_idx_i  (head_w.instr0.ra)
    ,.rb0_idx_i  (head_w.instr0.rb)
    ,.ra1_idx_i  (head_w.instr1.ra)
    ,.rb1_idx_i  (head_w.instr1.rb)
    ,.ra0_data_o (ra0_w)
    ,.rb0_data_o (rb0_w)
    ,.ra1_data_o (ra1_w)
    ,.rb1_data_o (rb1_w)
);

operand_bypass u_bypass_a
(
     .instr_i       (head_w.instr0)
    ,.ra_file_i     (ra0_w)
    ,.rb_file_i     (rb0_w)
    ,.pipe0_stage_i (pipe0_stage_w)
    ,.pipe1_stage_i (pipe1_stage_w)
    ,.issue_o       (issue_a_data_w)
);

operand_bypass u_bypass_b
(
     .instr_i       (head_w.instr1)
    ,.ra_file_i     (ra1_w)
    ,.rb_file_i     (rb1_w)
    ,.pipe0_stage_i (pipe0_stage_w)
    ,.pipe1_stage_i (pipe1_stage_w)
    ,.issue_o       (issue_b_data_w)
);

// ------------------------------------------------------------
// Execution pipes
// ------------------------------------------------------------
exec_pipe #(.SUPPORT_MUL(1)) u_pipe0
(
     .clk_i          (clk_i)
    ,.rst_i          (rst_i)
    ,.issue_valid_i  (issue_a_w)
    ,.issue_i        (issue_a_data_w)
    ,.e1_o           (pipe0_stage_w[issue_pkg::STAGE_E1])
    ,.e2_o           (pipe0_stage_w[issue_pkg::STAGE_E2])
    ,.wb_o           (pipe0_stage_w[issue_pkg::STAGE_WB])
    ,.commit_valid_o (commit0_valid_o)
    ,.commit_o       (commit0_o)
);

exec_pipe #(.SUPPORT_MUL(0)) u_pipe1
(
     .clk_i          (clk_i)
    ,.rst_i          (rst_i)
    ,.issue_valid_i  (issue_b_w)
    ,.issue_i        (issue_b_data_w)
    ,.e1_o           (pipe1_stage_w[issue_pkg::STAGE_E1])
    ,.e2_o           (pipe1_stage_w[issue_pkg::STAGE_E2])
    ,.wb_o           (pipe1_stage_w[issue_pkg::STAGE_WB])
    ,.commit_valid_o (commit1_valid_o)
    ,.commit_o       (commit1_o)
);

endmodule

//--- verilog/operand_bypass.sv
`timescale 1ns/10ps

module operand_bypass
(
     input  issue_pkg::instr_t          instr_i
    ,input  logic [issue_pkg::XLEN-1:0] ra_file_i
    ,input  logic [issue_pkg::XLEN-1:0] rb_file_i
    ,input  issue_pkg::stage_t          pipe0_stage_i [issue_pkg::NUM_STAGES]
    ,input  issue_pkg::stage_t          pipe1_stage_i [issue_pkg::NUM_STAGES]
    ,output issue_pkg::issue_t          issue_o
);

logic [issue_pkg::XLEN-1:0] ra_r;
logic [issue_pkg::XLEN-1:0] rb_r;

// Take the stage result if it writes the wanted register
function automatic logic [issue_pkg::XLEN-1:0] pick
(
    input issue_pkg::stage_t               stage,
    input logic [issue_pkg::REG_IDX_W-1:0] idx,
    input logic [issue_pkg::XLEN-1:0]      cur
);
    if (stage.valid && stage.wr && (stage.rd == idx))
        return stage.result;
    return cur;
endfunction

always_comb
begin
    ra_r = ra_file_i;
    rb_r = rb_file_i;

    // Oldest stage first so the newest producer is applied last
    for (int s = issue_pkg::STAGE_WB; s >= issue_pkg::STAGE_E1; s--)
    begin
        ra_r = pick(pipe0_stage_i[s], instr_i.ra, ra_r);
        rb_r = pick(pipe0_stage_i[s], instr_i.rb, rb_r);
        ra_r = pick(pipe1_stage_i[s], instr_i.ra, ra_r);
        rb_r = pick(pipe1_stage_i[s], instr_i.rb, rb_r);
    end

    if (instr_i.ra == '0)
        ra_r = '0;
    if (instr_i.rb == '0)
        rb_r = '0;
end

always_comb
begin
    issue_o.instr  = instr_i;
    issue_o.ra_val = ra_r;
    issue_o.rb_val = rb_r;
end

endmodule
